//--- hdl/byte_fifo.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module byte_fifo #(
    parameter int DEPTH = `HIST_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       not_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full      = (count == CW'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;     // a push into a full buffer is lost
    assign do_pop    = pop && not_empty;  // popping an empty buffer does nothing

    // show-ahead, the head entry is always on the output
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + AW'(1); // depth need not be a power of two
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + AW'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count; // both or neither leave the level alone
            endcase
        end
    end

endmodule

//--- hdl/char_hist_top.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module char_hist_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sclk,
    input  logic                     mosi,
    input  logic                     cs_n,
    input  logic                     bin_rd,
    input  logic [7:0]               bin_addr,
    output logic [`HIST_COUNT_W-1:0] bin_data,
    output logic                     bin_valid,
    output logic [`HIST_COUNT_W-1:0] total,
    output logic                     eof,
    output logic                     busy,
    output logic                     complete
);
    import hist_pkg::*;

    logic [7:0]               byte_data;  // assembled SPI byte
    logic                     byte_stb;
    logic [7:0]               fifo_data;  // head of the byte FIFO
    logic                     fifo_not_empty;
    logic                     fifo_pop;
    sram_op_t                 sram_op;
    logic [7:0]               sram_addr;
    logic [`HIST_COUNT_W-1:0] sram_wdata;
    logic [`HIST_COUNT_W-1:0] sram_rdata;

    spi_byte_rx u_spi_byte_rx (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .byte_data (byte_data),
        .byte_stb  (byte_stb)
    );

    byte_fifo #(
        .DEPTH (`HIST_FIFO_DEPTH)
    ) u_byte_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (byte_stb),
        .push_data (byte_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .not_empty (fifo_not_empty)
    );

    hist_engine u_hist_engine (
        .clk            (clk),
        .rst            (rst),
        .fifo_data      (fifo_data),
        .fifo_not_empty (fifo_not_empty),
        .fifo_pop       (fifo_pop),
        .sram_op        (sram_op),
        .sram_addr      (sram_addr),
        .sram_wdata     (sram_wdata),
        .sram_rdata     (sram_rdata),
        .bin_rd         (bin_rd),
        .bin_addr       (bin_addr),
        .bin_data       (bin_data),
        .bin_valid      (bin_valid),
        .total          (total),
        .eof            (eof),
        .busy           (busy),
        .complete       (complete)
    );

    hist_sram u_hist_sram (
        .clk     (clk),
        .sram_op (sram_op),
        .addr    (sram_addr),
        .wdata   (sram_wdata),
        .rdata   (sram_rdata)
    );

endmodule

//--- hdl/hist_defines.svh
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// number of histogram bins, one per byte value
`define HIST_BINS 256

// width of a bin, of the running total and of the readout
`define HIST_COUNT_W 32

// default byte FIFO depth
`define HIST_FIFO_DEPTH 8

// end-of-file character, counting stops for good when it arrives
`define HIST_EOF_CHAR 8'h1A

`endif

//--- hdl/hist_engine.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module hist_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [7:0]               fifo_data,
    input  logic                     fifo_not_empty,
    output logic                     fifo_pop,
    output hist_pkg::sram_op_t       sram_op,
    output logic [7:0]               sram_addr,
    output logic [`HIST_COUNT_W-1:0] sram_wdata,
    input  logic [`HIST_COUNT_W-1:0] sram_rdata,
    input  logic                     bin_rd,
    input  logic [7:0]               bin_addr,
    output logic [`HIST_COUNT_W-1:0] bin_data,
    output logic                     bin_valid,
    output logic [`HIST_COUNT_W-1:0] total,
    output logic                     eof,
    output logic                     busy,
    output logic                     complete
);
    import hist_pkg::*;

    engine_state_t state;
    engine_state_t ret_state;  // where a readout goes back to
    logic [7:0]    clr_addr;   // clear sweep position
    logic          rd_pending; // readout arrived during an update
    logic [7:0]    rd_addr_q;  // address of the pending readout
    logic          dump_cap;   // readout data is on sram_rdata this cycle
    logic          can_serve;
    logic          dump_req;

    assign busy      = (state == ST_CLEAR);
    assign can_serve = (state == ST_IDLE) || (state == ST_HALT);
    assign dump_req  = bin_rd || rd_pending;

    // a readout wins over the next byte, which waits in the FIFO
    assign fifo_pop = can_serve && fifo_not_empty && !dump_req;

    // SRAM controls are registered, so each one is live during the state it belongs to
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_CLEAR;
            ret_state  <= ST_IDLE;
            clr_addr   <= 8'd0;
            sram_op    <= OP_NOP;
            sram_addr  <= 8'd0;
            sram_wdata <= '0;
            total      <= '0;
            eof        <= 1'b0;
            complete   <= 1'b0;
            dump_cap   <= 1'b0;
        end else begin
            sram_op  <= OP_NOP;
            complete <= 1'b0;
            dump_cap <= 1'b0;
            case (state)
                ST_CLEAR: begin
                    sram_op    <= OP_WRITE;
                    sram_addr  <= clr_addr;
                    sram_wdata <= '0;
                    clr_addr   <= clr_addr + 8'd1;
                    if (clr_addr == 8'(`HIST_BINS - 1)) begin
                        state <= ST_IDLE; // last zero write lands during the first idle cycle
                    end
                end
                ST_IDLE, ST_HALT: begin
                    if (dump_req) begin
                        sram_op   <= OP_READ;
                        sram_addr <= bin_rd ? bin_addr : rd_addr_q;
                        ret_state <= state;
                        state     <= ST_DUMP;
                    end else if (fifo_not_empty && (state == ST_IDLE)) begin
                        if (fifo_data == `HIST_EOF_CHAR) begin
                            eof   <= 1'b1; // sticky until reset
                            state <= ST_HALT;
                        end else begin
                            sram_op   <= OP_READ;
                            sram_addr <= fifo_data; // the byte is its own bin address
                            state     <= ST_READ;
                        end
                    end
                end
                ST_READ: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    sram_op    <= OP_WRITE;
                    sram_wdata <= sram_rdata + `HIST_COUNT_W'(1);
                    state      <= ST_WRITE;
                end
                ST_WRITE: begin
                    total    <= total + `HIST_COUNT_W'(1);
                    complete <= 1'b1;
                    state    <= ST_IDLE;
                end
                ST_DUMP: begin
                    dump_cap <= 1'b1;
                    state    <= ret_state;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // a readout that cannot be served now waits for the update to finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else if (can_serve) begin
            rd_pending <= 1'b0; // taken by the FSM in this same cycle
        end else if (bin_rd && !busy) begin
            rd_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bin_rd && !busy && !can_serve) begin
            rd_addr_q <= bin_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bin_valid <= 1'b0;
        end else begin
            bin_valid <= dump_cap;
        end
    end

    always_ff @(posedge clk) begin
        if (dump_cap) begin
            bin_data <= sram_rdata;
        end
    end

endmodule

//--- hdl/hist_pkg.sv
package hist_pkg;

    // engine states, ST_CLEAR is the reset state
    typedef enum logic [2:0] {
        ST_CLEAR = 3'd0, // zero sweep over every bin
        ST_IDLE  = 3'd1, // waiting for a byte or a readout
        ST_READ  = 3'd2, // bin read issued to the SRAM
        ST_WAIT  = 3'd3, // read data comes back
        ST_WRITE = 3'd4, // incremented count goes back
        ST_HALT  = 3'd5, // end of file seen, bytes are drained
        ST_DUMP  = 3'd6  // readout read issued to the SRAM
    } engine_state_t;

    // SRAM opcodes.
    // one opcode per cycle, the memory is single ported
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0, // memory idles, rdata holds
        OP_READ  = 2'd1, // rdata is loaded on the next edge
        OP_WRITE = 2'd2  // wdata is stored at addr
    } sram_op_t;

endpackage

//--- hdl/hist_sram.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module hist_sram (
    input  logic                     clk,
    input  hist_pkg::sram_op_t       sram_op,
    input  logic [7:0]               addr,
    input  logic [`HIST_COUNT_W-1:0] wdata,
    output logic [`HIST_COUNT_W-1:0] rdata
);
    import hist_pkg::*;

    // contents are undefined at power up until the engine sweeps them to zero
    logic [`HIST_COUNT_W-1:0] mem [`HIST_BINS];

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        case (sram_op)
            OP_READ: begin
                rdata <= mem[addr]; // one cycle of read latency
            end
            OP_WRITE: begin
                mem[addr] <= wdata; // rdata keeps the last read value
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/spi_byte_rx.sv
`timescale 1ns/10ps

module spi_byte_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    output logic [7:0] byte_data,
    output logic       byte_stb
);

    logic       sclk_s1, sclk_s2; // sclk synchronizer stages
    logic       cs_n_s1, cs_n_s2; // chip select synchronizer stages
    logic       mosi_s1, mosi_s2; // data synchronizer stages
    logic       sclk_d;           // previous synchronized sclk for edge detect
    logic       sclk_rise;
    logic [2:0] bit_cnt;          // bits already shifted into the current byte

    // control pins come up idle: sclk low, chip select released
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_s1 <= 1'b0;
            sclk_s2 <= 1'b0;
            sclk_d  <= 1'b0;
            cs_n_s1 <= 1'b1;
            cs_n_s2 <= 1'b1;
        end else begin
            sclk_s1 <= sclk;
            sclk_s2 <= sclk_s1;
            sclk_d  <= sclk_s2;
            cs_n_s1 <= cs_n;
            cs_n_s2 <= cs_n_s1;
        end
    end

    always_ff @(posedge clk) begin
        mosi_s1 <= mosi;
        mosi_s2 <= mosi_s1; // lines up with sclk_s2
    end

    assign sclk_rise = sclk_s2 & ~sclk_d; // mode 0 samples on the rising edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt  <= 3'd0;
            byte_stb <= 1'b0;
        end else begin
            byte_stb <= 1'b0;
            if (cs_n_s2) begin
                bit_cnt <= 3'd0; // a deselect abandons any partial byte
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1; // wraps to zero after the eighth bit
                if (bit_cnt == 3'd7) begin
                    byte_stb <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!cs_n_s2 && sclk_rise) begin
            byte_data <= {byte_data[6:0], mosi_s2}; // msb arrives first
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module char_hist_tb -f verilog.f \
    -o char_hist_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/char_hist_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- verification/char_hist_properties.sv
`timescale 1ns/10ps

module char_hist_properties (
    input logic                    clk,
    input logic                    rst,
    input hist_pkg::engine_state_t state,
    input hist_pkg::sram_op_t      sram_op,
    input logic                    eof,
    input logic                    bin_valid,
    input logic                    fifo_push,
    input logic                    fifo_full
);
    import hist_pkg::*;

    // end of file is sticky until reset
    eof_sticky: assert property (@(posedge clk) disable iff (rst) eof |=> eof)
        else $error("eof fell without a reset");

    // one SPI byte takes far longer than an update, so the FIFO never fills
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(fifo_push && fifo_full))
        else $error("byte pushed into a full FIFO");

    // the dump read returns on the next cycle and is registered once more
    dump_latency: assert property (@(posedge clk) disable iff (rst)
                                   $past(state == ST_DUMP, 2) |-> bin_valid)
        else $error("bin_valid did not follow a dump read by two cycles");

    halt_no_write: assert property (@(posedge clk) disable iff (rst)
                                    (state == ST_HALT) |-> (sram_op != OP_WRITE))
        else $error("SRAM write while halted");

endmodule

// engine instance, the FIFO ports are tied off
bind hist_engine char_hist_properties u_engine_props (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .sram_op   (sram_op),
    .eof       (eof),
    .bin_valid (bin_valid),
    .fifo_push (1'b0),
    .fifo_full (1'b0)
);

// FIFO instance, the engine ports are tied to idle values
bind byte_fifo char_hist_properties u_fifo_props (
    .clk       (clk),
    .rst       (rst),
    .state     (hist_pkg::ST_IDLE),
    .sram_op   (hist_pkg::OP_NOP),
    .eof       (1'b0),
    .bin_valid (1'b0),
    .fifo_push (push),
    .fifo_full (full)
);

//--- verification/char_hist_tb.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module char_hist_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int SPI_HALF     = 4;                         // clk cycles per sclk half period
    localparam int SEED         = 32'hdf8f;
    localparam int BYTE_CYCLES  = 2 * SPI_HALF * 8 + 4 * SPI_HALF; // shifting plus select gaps
    localparam int STREAM_BYTES = 60;
    localparam int TEST_BYTES   = 4 + 200 + STREAM_BYTES + 1 + 6;
    localparam int TEST_READS   = 3 * `HIST_BINS + 100;
    localparam int READ_CYCLES  = 24;                        // pulse, latency and random gap
    localparam int WATCHDOG_CYCLES = 2 * (TEST_BYTES * BYTE_CYCLES + TEST_READS * READ_CYCLES
                                          + `HIST_BINS + 16);

    logic                     clk;
    logic                     rst;
    logic                     sclk;
    logic                     mosi;
    logic                     cs_n;
    logic                     bin_rd;
    logic [7:0]               bin_addr;
    logic [`HIST_COUNT_W-1:0] bin_data;
    logic                     bin_valid;
    logic [`HIST_COUNT_W-1:0] total;
    logic                     eof;
    logic                     busy;
    logic                     complete;

    logic [`HIST_COUNT_W-1:0] model_bins [`HIST_BINS]; // counts of bytes known to be binned
    logic [`HIST_COUNT_W-1:0] model_total;
    logic [7:0]               inflight_byte;           // byte sent but maybe not yet binned
    logic                     inflight_valid;
    logic                     model_halted;            // end of file has been sent
    logic                     stream_done;
    int                       complete_count;

    char_hist_top DUT (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .bin_rd    (bin_rd),
        .bin_addr  (bin_addr),
        .bin_data  (bin_data),
        .bin_valid (bin_valid),
        .total     (total),
        .eof       (eof),
        .busy      (busy),
        .complete  (complete)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (!rst && complete) begin
            complete_count <= complete_count + 1; // one pulse per bin update
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = 8'($urandom);
        while (b == `HIST_EOF_CHAR) begin
            b = 8'($urandom); // the end-of-file byte would stop the histogram
        end
        return b;
    endfunction

    function automatic void commit_inflight();
        if (inflight_valid) begin
            model_bins[inflight_byte] = model_bins[inflight_byte] + 32'd1;
            model_total = model_total + 32'd1;
            inflight_valid = 1'b0;
        end
    endfunction

    // mode 0, data is set while sclk is low and sampled on its rising edge
    task automatic spi_send_byte(input logic [7:0] value);
        commit_inflight(); // the previous byte has long been binned by now
        if (model_halted || value == `HIST_EOF_CHAR) begin
            model_halted = 1'b1;
        end else begin
            inflight_byte  = value;
            inflight_valid = 1'b1;
        end
        @(posedge clk);
        #5;
        cs_n = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            mosi = value[i];
            wait_cycles(SPI_HALF);
            sclk = 1'b1;
            wait_cycles(SPI_HALF);
            sclk = 1'b0;
        end
        wait_cycles(SPI_HALF);
        cs_n = 1'b1;
        wait_cycles(2 * SPI_HALF);
    endtask

    task automatic read_bin(input logic [7:0] addr, output logic [31:0] value);
        int n;
        @(posedge clk);
        #5;
        bin_rd   = 1'b1;
        bin_addr = addr;
        wait_cycles(1);
        bin_rd = 1'b0; // a single cycle strobe
        n = 0;
        while (!bin_valid && n < 40) begin
            wait_cycles(1);
            n++;
        end
        if (!bin_valid) begin
            stop_with_error($sformatf("no bin_valid after a read of bin %0d", addr));
        end
        value = bin_data;
    endtask

    task automatic wait_settled(input string name);
        logic [31:0] expected;
        int          n;
        expected = model_total + (inflight_valid ? 32'd1 : 32'd0);
        n = 0;
        while (total !== expected && n < 200) begin
            wait_cycles(1);
            n++;
        end
        check_value(name, expected, total);
        commit_inflight();
    endtask

    task automatic check_all_bins(input string name);
        logic [31:0] value;
        for (int i = 0; i < `HIST_BINS; i++) begin
            read_bin(8'(i), value);
            check_value($sformatf("%s bin %0d", name, i), model_bins[i], value);
        end
        check_value($sformatf("%s total", name), model_total, total);
    endtask

    task automatic test_reset_state();
        logic [31:0] value;
        int          n;
        n = 0;
        while (busy && n < 2 * `HIST_BINS) begin
            wait_cycles(1);
            n++;
        end
        if (busy) begin
            stop_with_error("busy stayed high after the clear sweep should have ended");
        end
        read_bin(8'd0, value);
        check_value("reset bin 0", 32'd0, value);
        read_bin(8'd255, value);
        check_value("reset bin 255", 32'd0, value);
        for (int a = 17; a < 255; a += 17) begin
            read_bin(8'(a), value);
            check_value($sformatf("reset bin %0d", a), 32'd0, value);
        end
        check_value("reset total", 32'd0, total);
        check_value("reset eof", 32'd0, 32'(eof));
    endtask

    task automatic test_basic_counts();
        logic [31:0] value;
        int          pulses_before;
        pulses_before = complete_count;
        spi_send_byte(8'h41);
        spi_send_byte(8'h41);
        spi_send_byte(8'h41);
        spi_send_byte(8'h00);
        wait_settled("basic settle");
        read_bin(8'h41, value);
        check_value("basic bin 0x41", 32'd3, value);
        read_bin(8'h00, value);
        check_value("basic bin 0x00", 32'd1, value);
        check_value("basic total", 32'd4, total);
        check_value("basic complete pulses", 32'd4, 32'(complete_count - pulses_before));
    endtask

    task automatic test_random_stream();
        for (int n = 0; n < 200; n++) begin
            spi_send_byte(random_byte());
        end
        wait_settled("random settle");
        check_all_bins("random");
    endtask

    task automatic test_reads_during_stream();
        logic [7:0]  addr;
        logic [31:0] expected;
        logic [31:0] value;
        logic        maybe_plus;
        stream_done = 1'b0;
        fork
            begin
                for (int n = 0; n < STREAM_BYTES; n++) begin
                    spi_send_byte(random_byte());
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done) begin
                    addr = ($urandom_range(1, 0) == 1) ? inflight_byte : 8'($urandom);
                    expected   = model_bins[addr];
                    maybe_plus = inflight_valid && (inflight_byte == addr); // not yet binned
                    read_bin(addr, value);
                    if (maybe_plus && value === expected + 32'd1) begin
                        expected = expected + 32'd1; // the in-flight byte landed first
                    end
                    check_value($sformatf("live bin %0d", addr), expected, value);
                    wait_cycles($urandom_range(15, 0));
                end
            end
        join
        wait_settled("live settle");
        check_all_bins("live final");
    endtask

    task automatic test_eof_halt();
        int n;
        spi_send_byte(`HIST_EOF_CHAR);
        n = 0;
        while (!eof && n < 200) begin
            wait_cycles(1);
            n++;
        end
        if (!eof) begin
            stop_with_error("eof did not rise after the end-of-file byte");
        end
        for (int k = 0; k < 6; k++) begin
            spi_send_byte((k == 0) ? 8'h41 : random_byte()); // all of these are dropped
        end
        wait_settled("halt settle");
        check_value("halt eof", 32'd1, 32'(eof));
        check_all_bins("halt");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_error($sformatf("timeout: tests did not end within %0d clock cycles",
                                  WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(SEED));
        clk            = 1'b0;
        rst            = 1'b1;
        sclk           = 1'b0;
        mosi           = 1'b0;
        cs_n           = 1'b1;
        bin_rd         = 1'b0;
        bin_addr       = 8'd0;
        model_total    = '0;
        inflight_byte  = 8'd0;
        inflight_valid = 1'b0;
        model_halted   = 1'b0;
        stream_done    = 1'b0;
        complete_count = 0;
        for (int i = 0; i < `HIST_BINS; i++) begin
            model_bins[i] = '0;
        end
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        test_reset_state();
        test_basic_counts();
        test_random_stream();
        test_reads_during_stream();
        test_eof_halt();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/hist_pkg.sv
hdl/spi_byte_rx.sv
hdl/byte_fifo.sv
hdl/hist_sram.sv
hdl/hist_engine.sv
hdl/char_hist_top.sv
verification/char_hist_properties.sv
verification/char_hist_tb.sv
